// ==== Bender.yml ====
package:
  name: rv64_decode_stage

sources:
  - files:
      - verilog/rv64_pkg.sv
      - verilog/decoder.sv
      - verilog/imm_gen.sv
      - verilog/regfile.sv
      - verilog/decode_reg.sv
      - verilog/decode_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/decode_stage_tb.sv

// ==== all.f ====
+incdir+bench
verilog/rv64_pkg.sv
verilog/decoder.sv
verilog/imm_gen.sv
verilog/regfile.sv
verilog/decode_reg.sv
verilog/decode_stage.sv
bench/decode_stage_tb.sv

// ==== bench/decode_model.svh ====
word_t shadow [32];  // Mirrors the DUT register file

function automatic void classify_instr(input instr_t w, output decode_op_t op,
                                       output alufunc_t fn, output logic wr);
    alufunc_t base_tab [8];
    alufunc_t mul_tab [8];
    funct3_t  f3;
    funct7_t  f7;
    base_tab = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    mul_tab  = '{MULT, NOTALU, NOTALU, NOTALU, DIV, DIVU, REM, REMU};
    f3 = w[14:12];
    f7 = w[31:25];
    fn = NOTALU;
    wr = 1'b0;
    case (w[6:0])
        7'b0110111: op = LUI;
        7'b0010111: op = AUIPC;
        7'b1101111: op = JAL;
        7'b1100111: op = JALR;
        7'b0000011: op = LD;
        7'b0100011: op = SD;
        default: op = UNKNOWN;
    endcase
    if (op != UNKNOWN) begin
        fn = (op == LUI) ? CPYB : ADD;
        wr = (op != SD);
    end
    case (w[6:0])
        7'b0010011, 7'b0011011: begin
            op = w[3] ? ALUIW : ALUI;  // Bit 3 marks the 32-bit forms
            fn = (f3 == 3'd5 && w[30]) ? SRA : base_tab[f3];
            wr = 1'b1;
        end
        7'b0110011, 7'b0111011: begin
            if (f7 == 7'h00) fn = base_tab[f3];
            else if (f7 == 7'h01) fn = mul_tab[f3];
            else if (f7 == 7'h20 && f3 == 3'd0) fn = SUB;
            else if (f7 == 7'h20 && f3 == 3'd5) fn = SRA;
            if (fn != NOTALU) begin
                op = w[3] ? ALUW : ALU;
                wr = 1'b1;
            end
        end
        7'b1100011: begin
            if (f3[2:1] != 2'b01) begin
                op = f3[0] ? BNZ : BZ;
                fn = !f3[2] ? EQL : (f3[1] ? SLTU : SLT);
            end
        end
        7'b1110011: begin
            if (f3 == 3'd0) begin
                if (f7 == 7'h00) op = ECALL;
                else if (f7 == 7'h18) op = MRET;
                else if (f7 == 7'h09) op = SFENCE;
                fn = (op == ECALL) ? ALU_ECALL : (op == MRET) ? ALU_MRET : NOTALU;
            end else if (f3 != 3'd4) begin
                op = f3[2] ? CSRI : CSR;
                fn = (f3[1:0] == 2'b01) ? ALU_CSRW :
                     (f3[1:0] == 2'b10) ? ALU_CSRS : ALU_CSRC;
                wr = 1'b1;
            end
        end
        default: ;
    endcase
endfunction

function automatic word_t build_imm(input instr_t w);
    logic signed [63:0] sw;
    logic [12:0]        b;
    logic [20:0]        j;
    word_t              imm;
    sw = {{32{w[31]}}, w};
    b  = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    j  = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    case (w[6:0])
        7'b0010011, 7'b0011011, 7'b0000011, 7'b1100111: imm = sw >>> 20;
        7'b0100011: begin
            imm      = sw >>> 20;
            imm[4:0] = w[11:7];  // Low bits sit in the rd field
        end
        7'b1100011: imm = {{51{b[12]}}, b};
        7'b0110111, 7'b0010111: imm = sw & ~64'hfff;
        7'b1101111: imm = {{43{j[20]}}, j};
        7'b1110011: imm = w[19:15];  // zimm, zero extended
        default: imm = '0;
    endcase
    return imm;
endfunction

function automatic word_t shadow_read(input reg_idx_t idx, input wb_req_t w);
    if (idx == 0)
        return '0;
    if (w.en && w.rd == idx)
        return w.data;  // Write in the accepting cycle
    return shadow[idx];
endfunction

function automatic decoded_t expected_dec(input fetch_pkt_t p, input wb_req_t w);
    decoded_t   d;
    decode_op_t op;
    alufunc_t   fn;
    logic       wr;
    classify_instr(p.instr, op, fn, wr);
    d.pc       = p.pc;
    d.op       = op;
    d.alufunc  = fn;
    d.regwrite = wr;
    d.rd       = p.instr[11:7];
    d.rs1      = p.instr[19:15];
    d.rs2      = p.instr[24:20];
    d.imm      = build_imm(p.instr);
    d.rs1_data = shadow_read(d.rs1, w);
    d.rs2_data = shadow_read(d.rs2, w);
    d.funct3   = p.instr[14:12];
    return d;
endfunction

// ==== bench/decode_stage_tb.sv ====
module decode_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv64_pkg::*;

    localparam int n_instr    = 2000;
    localparam int max_cycles = n_instr + 4000;
    localparam opcode_t opcodes [12] = '{7'b0110011, 7'b1110011, 7'b0010011, 7'b0011011,
        7'b0111011, 7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
        7'b0000011, 7'b0100011};
    localparam funct7_t op_f7 [3]  = '{7'h00, 7'h20, 7'h01};
    localparam funct7_t sys_f7 [3] = '{7'h00, 7'h18, 7'h09};

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    fetch_pkt_t in_pkt;
    logic       out_valid;
    logic       out_ready;
    decoded_t   out_dec;
    wb_req_t    wb;

    decoded_t exp_q [$];
    decoded_t held;
    logic     run;
    logic     done;
    logic     in_fire;
    logic     accept_prev;
    logic     stall_prev;
    int       cycles;
    int       accepted;
    int       checked;
    int       mismatches;
    int       other_errors;

    `include "decode_model.svh"

    decode_stage decode_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_pkt    (in_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec),
        .wb        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic reg_idx_t random_reg();
        reg_idx_t r;
        r = $urandom_range(0, 31);
        if ($urandom_range(0, 1) == 1)
            r = r % 4;  // Crowd low indices for bypass hits
        return r;
    endfunction

    function automatic instr_t random_instr();
        instr_t      w;
        int unsigned pick;
        int unsigned k;
        w = $urandom();
        w[19:15] = random_reg();
        w[24:20] = random_reg();
        pick = $urandom_range(0, 15);
        if (pick < 14) begin  // Otherwise a raw random word
            w[6:0] = opcodes[pick % 12];
            k = $urandom_range(0, 3);
            if (k < 3 && w[6:0] == 7'b1110011)
                w[31:25] = sys_f7[k];
            else if (k < 3 && w[6:0] inside {7'b0110011, 7'b0111011})
                w[31:25] = op_f7[k];
        end
        return w;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else begin
            mismatches++;
            $display("mismatch at %0t: field %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_dec(input decoded_t got, input decoded_t exp);
        check_field("pc", got.pc, exp.pc);
        check_field("op", got.op, exp.op);
        check_field("alufunc", got.alufunc, exp.alufunc);
        check_field("regwrite", got.regwrite, exp.regwrite);
        check_field("rd", got.rd, exp.rd);
        check_field("rs1", got.rs1, exp.rs1);
        check_field("rs2", got.rs2, exp.rs2);
        check_field("imm", got.imm, exp.imm);
        check_field("rs1_data", got.rs1_data, exp.rs1_data);
        check_field("rs2_data", got.rs2_data, exp.rs2_data);
        check_field("funct3", got.funct3, exp.funct3);
        checked++;
    endtask

    // Samples mid-cycle, so each check looks at the transfer of the next edge
    always @(negedge clk) begin
        if (rst_n && run) begin
            cycles++;
            if (accept_prev) begin
                assert (out_valid)
                else begin
                    other_errors++;
                    $display("Accepted instruction not valid one cycle later, time %0t", $time);
                end
            end
            if (stall_prev) begin
                assert (out_valid && out_dec === held)
                else begin
                    mismatches++;
                    $display("mismatch at %0t: stalled output dropped or changed", $time);
                end
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0)
                else begin
                    other_errors++;
                    $display("Output transfer with no instruction pending, time %0t", $time);
                end
                if (exp_q.size() != 0)
                    compare_dec(out_dec, exp_q.pop_front());
            end
            in_fire = in_valid && in_ready;
            if (in_fire) begin
                exp_q.push_back(expected_dec(in_pkt, wb));
                accepted++;
            end
            accept_prev = in_fire;
            stall_prev  = out_valid && !out_ready;
            held        = out_dec;
            if (wb.en && wb.rd != 0)
                shadow[wb.rd] = wb.data;
            done = (accepted == n_instr) && (exp_q.size() == 0);
        end
    end

    initial begin
        wait (run);
        forever begin
            @(posedge clk);
            #2;
            if (!in_valid || in_fire) begin
                in_valid     = (accepted < n_instr) && ($urandom_range(0, 3) != 0);
                in_pkt.pc    = {$urandom(), $urandom()} & ~64'h3;
                in_pkt.instr = random_instr();
            end
            out_ready = cycles[6] || ($urandom_range(0, 2) != 0);  // Stretches without stall
            wb.en     = $urandom_range(0, 1);
            wb.rd     = random_reg();
            wb.data   = {$urandom(), $urandom()};
        end
    end

    initial begin
        wait (cycles >= max_cycles);
        $display("Timeout after %0d cycles, %0d of %0d instructions accepted",
                 cycles, accepted, n_instr);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(23));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_pkt = '0;
        out_ready = 1'b0;
        wb = '0;
        {run, done, in_fire, accept_prev, stall_prev} = '0;
        {cycles, accepted, checked, mismatches, other_errors} = '0;
        foreach (shadow[i])
            shadow[i] = '0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && in_ready)
        else begin
            other_errors++;
            $display("Stage not idle and ready after reset");
        end
        run = 1'b1;
        wait (done);
        @(negedge clk);
        $display("Checked %0d of %0d instructions, %0d mismatches, %0d other errors",
                 checked, n_instr, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0 && checked == n_instr)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verilog/decode_reg.sv ====
module decode_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  rv64_pkg::decoded_t in_dec,
    output logic               out_valid,
    input  logic               out_ready,
    output rv64_pkg::decoded_t out_dec
);

    logic load;

    // Free slot, or the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;  // Drops when drained without refill
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_dec <= in_dec;
        end
    end

    // A stalled entry must neither vanish nor change
    a_out_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_dec)
    ) else $error("decode_reg: output changed under back-pressure");

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid)
    ) else $error("decode_reg: out_valid unknown");

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  rv64_pkg::fetch_pkt_t in_pkt,
    output logic                 out_valid,
    input  logic                 out_ready,
    output rv64_pkg::decoded_t   out_dec,
    input  rv64_pkg::wb_req_t    wb
);
    import rv64_pkg::*;

    decoded_t dec;

    // Raw fields straight from the instruction word
    assign dec.pc     = in_pkt.pc;
    assign dec.rd     = in_pkt.instr[11:7];
    assign dec.rs1    = in_pkt.instr[19:15];
    assign dec.rs2    = in_pkt.instr[24:20];
    assign dec.funct3 = in_pkt.instr[14:12];

    decoder decoder_i (
        .instr    (in_pkt.instr),
        .op       (dec.op),
        .alufunc  (dec.alufunc),
        .regwrite (dec.regwrite)
    );

    imm_gen imm_gen_i (
        .instr (in_pkt.instr),
        .imm   (dec.imm)
    );

    regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (dec.rs1_data),
        .rs2_data (dec.rs2_data),
        .wb       (wb)
    );

    decode_reg decode_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_dec    (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_dec   (out_dec)
    );

    // Fetch must hold its packet while stalled
    a_in_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> $stable(in_pkt)
    ) else $error("decode_stage: in_pkt changed while stalled");

endmodule

// ==== verilog/decoder.sv ====
module decoder (
    input  rv64_pkg::instr_t     instr,
    output rv64_pkg::decode_op_t op,
    output rv64_pkg::alufunc_t   alufunc,
    output logic                 regwrite
);
    import rv64_pkg::*;

    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    alufunc_t imm_func;
    alufunc_t rr_func;

    // Shared by OP-IMM, OP-IMM-32 and the base OP forms
    function automatic alufunc_t base_func(input funct3_t f3, input logic alt);
        alufunc_t f;
        case (f3)
            3'b000: f = ADD;
            3'b001: f = SLL;
            3'b010: f = SLT;
            3'b011: f = SLTU;
            3'b100: f = XOR;
            3'b101: f = alt ? SRA : SRL;
            3'b110: f = OR;
            default: f = AND;
        endcase
        return f;
    endfunction

    // Register-register forms, OP and OP-32
    function automatic alufunc_t reg_func(input funct3_t f3, input funct7_t f7);
        alufunc_t f;
        f = NOTALU;
        if (f7 == f7_base) begin
            f = base_func(f3, 1'b0);
        end else if (f7 == f7_alt) begin
            case (f3)
                3'b000: f = SUB;
                3'b101: f = SRA;
                default: f = NOTALU;
            endcase
        end else if (f7 == f7_muldiv) begin
            case (f3)
                3'b000: f = MULT;
                3'b100: f = DIV;
                3'b101: f = DIVU;
                3'b110: f = REM;
                3'b111: f = REMU;
                default: f = NOTALU;  // MULH variants not supported
            endcase
        end
        return f;
    endfunction

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign imm_func = base_func(funct3, instr[30]);
    assign rr_func  = reg_func(funct3, funct7);

    always_comb begin
        case (opcode)
            opc_op_imm: begin
                op       = ALUI;
                alufunc  = imm_func;
                regwrite = 1'b1;
            end
            opc_op_imm_32: begin
                op       = ALUIW;
                alufunc  = imm_func;
                regwrite = 1'b1;
            end
            opc_op: begin
                op       = (rr_func == NOTALU) ? UNKNOWN : ALU;
                alufunc  = rr_func;
                regwrite = (rr_func != NOTALU);
            end
            opc_op_32: begin
                op       = (rr_func == NOTALU) ? UNKNOWN : ALUW;
                alufunc  = rr_func;
                regwrite = (rr_func != NOTALU);
            end
            opc_lui: begin
                op       = LUI;
                alufunc  = CPYB;
                regwrite = 1'b1;
            end
            opc_auipc: begin
                op       = AUIPC;
                alufunc  = ADD;
                regwrite = 1'b1;
            end
            opc_jal: begin
                op       = JAL;
                alufunc  = ADD;
                regwrite = 1'b1;
            end
            opc_jalr: begin
                op       = JALR;
                alufunc  = ADD;
                regwrite = 1'b1;
            end
            opc_branch: begin
                regwrite = 1'b0;
                op       = funct3[0] ? BNZ : BZ;  // Taken on nonzero compare
                case (funct3[2:1])
                    2'b00: alufunc = EQL;
                    2'b10: alufunc = SLT;
                    2'b11: alufunc = SLTU;
                    default: begin
                        op      = UNKNOWN;
                        alufunc = NOTALU;
                    end
                endcase
            end
            opc_load: begin
                op       = LD;
                alufunc  = ADD;
                regwrite = 1'b1;
            end
            opc_store: begin
                op       = SD;
                alufunc  = ADD;
                regwrite = 1'b0;
            end
            opc_system: begin
                case (funct3)
                    3'b000: begin
                        regwrite = 1'b0;
                        case (funct7)
                            f7_base: begin
                                op      = ECALL;
                                alufunc = ALU_ECALL;
                            end
                            f7_mret: begin
                                op      = MRET;
                                alufunc = ALU_MRET;
                            end
                            f7_sfence: begin
                                op      = SFENCE;
                                alufunc = NOTALU;
                            end
                            default: begin
                                op      = UNKNOWN;
                                alufunc = NOTALU;
                            end
                        endcase
                    end
                    3'b100: begin
                        op       = UNKNOWN;
                        alufunc  = NOTALU;
                        regwrite = 1'b0;
                    end
                    default: begin
                        op       = funct3[2] ? CSRI : CSR;  // Bit 2 picks zimm form
                        regwrite = 1'b1;
                        case (funct3[1:0])
                            2'b01: alufunc = ALU_CSRW;
                            2'b10: alufunc = ALU_CSRS;
                            default: alufunc = ALU_CSRC;
                        endcase
                    end
                endcase
            end
            default: begin
                op       = UNKNOWN;
                alufunc  = NOTALU;
                regwrite = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/imm_gen.sv ====
module imm_gen (
    input  rv64_pkg::instr_t instr,
    output rv64_pkg::word_t  imm
);
    import rv64_pkg::*;

    opcode_t opcode;
    logic    sign;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_j;
    word_t   imm_z;

    assign opcode = instr[6:0];
    assign sign   = instr[31];

    assign imm_i = {{(xlen_w-12){sign}}, instr[31:20]};
    assign imm_s = {{(xlen_w-12){sign}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(xlen_w-13){sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{(xlen_w-32){sign}}, instr[31:12], 12'b0};
    assign imm_j = {{(xlen_w-21){sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_z = {{(xlen_w-5){1'b0}}, instr[19:15]};  // CSR zimm, no sign

    always_comb begin
        case (opcode)
            opc_op_imm,
            opc_op_imm_32,
            opc_load,
            opc_jalr:   imm = imm_i;
            opc_store:  imm = imm_s;
            opc_branch: imm = imm_b;
            opc_lui,
            opc_auipc:  imm = imm_u;
            opc_jal:    imm = imm_j;
            opc_system: imm = imm_z;
            default:    imm = '0;
        endcase
    end

endmodule

// ==== verilog/regfile.sv ====
module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  rv64_pkg::reg_idx_t rs1,
    input  rv64_pkg::reg_idx_t rs2,
    output rv64_pkg::word_t    rs1_data,
    output rv64_pkg::word_t    rs2_data,
    input  rv64_pkg::wb_req_t  wb
);
    import rv64_pkg::*;

    word_t regs [nregs];
    logic  wr_en;

    // Write of x0 is dropped here
    assign wr_en = wb.en && (wb.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    function automatic word_t read_port(input reg_idx_t idx);
        word_t d;
        if (idx == '0) begin
            d = '0;
        end else if (wr_en && (wb.rd == idx)) begin
            d = wb.data;  // Same-cycle writeback bypass
        end else begin
            d = regs[idx];
        end
        return d;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

// ==== verilog/rv64_pkg.sv ====
package rv64_pkg;

    localparam int xlen_w = 64;
    localparam int nregs  = 32;

    typedef logic [31:0]       instr_t;
    typedef logic [xlen_w-1:0] addr_t;
    typedef logic [xlen_w-1:0] word_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [6:0]        opcode_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [6:0]        funct7_t;

    // Major opcodes, RV64I base map
    localparam opcode_t opc_op_imm    = 7'b0010011;
    localparam opcode_t opc_op        = 7'b0110011;
    localparam opcode_t opc_op_imm_32 = 7'b0011011;
    localparam opcode_t opc_op_32     = 7'b0111011;
    localparam opcode_t opc_lui       = 7'b0110111;
    localparam opcode_t opc_auipc     = 7'b0010111;
    localparam opcode_t opc_jal       = 7'b1101111;
    localparam opcode_t opc_jalr      = 7'b1100111;
    localparam opcode_t opc_branch    = 7'b1100011;
    localparam opcode_t opc_load      = 7'b0000011;
    localparam opcode_t opc_store     = 7'b0100011;
    localparam opcode_t opc_system    = 7'b1110011;

    localparam funct7_t f7_base   = 7'b0000000;
    localparam funct7_t f7_alt    = 7'b0100000;  // SUB and SRA
    localparam funct7_t f7_muldiv = 7'b0000001;
    localparam funct7_t f7_mret   = 7'b0011000;
    localparam funct7_t f7_sfence = 7'b0001001;

    typedef enum logic [4:0] {
        ALUI, ALU, ALUIW, ALUW, LUI, JAL, JALR, BZ, BNZ, LD, SD, AUIPC,
        CSR, CSRI, ECALL, MRET, SFENCE, UNKNOWN
    } decode_op_t;

    typedef enum logic [4:0] {
        ADD, SUB, XOR, OR, AND, SLT, SLTU, SLL, SRL, SRA,
        MULT, DIV, DIVU, REM, REMU, EQL, CPYB,
        ALU_CSRW, ALU_CSRS, ALU_CSRC, ALU_ECALL, ALU_MRET, NOTALU
    } alufunc_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } wb_req_t;

    typedef struct packed {
        addr_t      pc;
        decode_op_t op;
        alufunc_t   alufunc;
        logic       regwrite;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        word_t      imm;
        word_t      rs1_data;  // Sampled at acceptance
        word_t      rs2_data;
        funct3_t    funct3;
    } decoded_t;

endpackage
